// File: common/icache_pkg.sv
package icache_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // cache geometry
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int WORD_SIZE      = 32;
    localparam int BYTE_OFF_SIZE  = 2;
    localparam int WORD_OFF_SIZE  = 2;
    localparam int INDEX_SIZE     = 3;
    localparam int NUM_LINES      = 8;
    localparam int WORDS_PER_LINE = 4;

    // whatever is left of the address above index and offsets
    localparam int TAG_SIZE = WORD_SIZE - INDEX_SIZE - WORD_OFF_SIZE - BYTE_OFF_SIZE;

    // ~~~~~~~~~~~~~~~~~~~~
    // types
    // ~~~~~~~~~~~~~~~~~~~~

    typedef logic [WORD_SIZE-1:0]     word_t;
    typedef logic [INDEX_SIZE-1:0]    index_t;
    typedef logic [WORD_OFF_SIZE-1:0] word_off_t;
    typedef logic [TAG_SIZE-1:0]      tag_t;

    // controller states, the two refill states carry one APB read
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL_SETUP,
        REFILL_ACCESS,
        RESPOND
    } ctrl_state_t;

endpackage : icache_pkg

// File: common/icache_array_if.sv
`timescale 1ns/100ps

interface icache_array_if;
    import icache_pkg::*;

    // driven by the controller
    word_t     lookup_addr;
    logic      fill_we;
    word_off_t fill_word;
    word_t     fill_data;
    logic      tag_we;
    logic      flush;

    // returned by the arrays
    logic      hit;
    word_t     rdata;

    modport ctrl (output lookup_addr, fill_we, fill_word, fill_data, tag_we, flush,
                  input  hit, rdata);

    modport tag  (input  lookup_addr, tag_we, flush,
                  output hit);

    modport data (input  lookup_addr, fill_we, fill_word, fill_data,
                  output rdata);

endinterface : icache_array_if

// File: icache/icache_tag.sv
`timescale 1ns/100ps

module icache_tag (
    input  logic               clk_i,
    input  logic               arst_n_i,
    icache_array_if.tag        arr_if
);
    import icache_pkg::*;

    tag_t                 addr_tag;
    index_t               addr_index;
    logic [NUM_LINES-1:0] valid_q;
    tag_t                 tag_q [NUM_LINES];

    // ~~~~~~~~~~~~~~~~~~~~
    // address split
    // ~~~~~~~~~~~~~~~~~~~~

    assign addr_tag   = arr_if.lookup_addr[WORD_SIZE-1:WORD_SIZE-TAG_SIZE];
    assign addr_index = arr_if.lookup_addr[BYTE_OFF_SIZE+WORD_OFF_SIZE +: INDEX_SIZE];

    // ~~~~~~~~~~~~~~~~~~~~
    // tag store
    // ~~~~~~~~~~~~~~~~~~~~

    // a flush drops any tag write that lands in the same cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            for (int i = 0; i < NUM_LINES; i++) begin
                tag_q[i] <= '0;
            end
        end else if (arr_if.flush) begin
            valid_q <= '0;
        end else if (arr_if.tag_we) begin
            valid_q[addr_index] <= 1'b1;
            tag_q[addr_index]   <= addr_tag;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // hit detection
    // ~~~~~~~~~~~~~~~~~~~~

    // direct mapped, so only the indexed line is compared
    always_comb begin
        arr_if.hit = valid_q[addr_index] && (tag_q[addr_index] == addr_tag);
    end

endmodule : icache_tag

// File: icache/icache_data.sv
`timescale 1ns/100ps

module icache_data (
    input  logic               clk_i,
    input  logic               arst_n_i,
    icache_array_if.data       arr_if
);
    import icache_pkg::*;

    word_t     mem_q [NUM_LINES][WORDS_PER_LINE];
    word_t     rdata_q;
    index_t    line_idx;
    word_off_t word_idx;

    // ~~~~~~~~~~~~~~~~~~~~
    // addressing
    // ~~~~~~~~~~~~~~~~~~~~

    assign line_idx = arr_if.lookup_addr[BYTE_OFF_SIZE+WORD_OFF_SIZE +: INDEX_SIZE];
    assign word_idx = arr_if.lookup_addr[BYTE_OFF_SIZE +: WORD_OFF_SIZE];

    // ~~~~~~~~~~~~~~~~~~~~
    // line storage
    // ~~~~~~~~~~~~~~~~~~~~

    // refill writes the word picked by the controller, not the fetch offset
    always_ff @(posedge clk_i) begin
        if (arr_if.fill_we) begin
            mem_q[line_idx][arr_if.fill_word] <= arr_if.fill_data;
        end
    end

    // read port is registered, so data trails the address by one cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_q <= '0;
        end else begin
            rdata_q <= mem_q[line_idx][word_idx];
        end
    end

    assign arr_if.rdata = rdata_q;

endmodule : icache_data

// File: icache/icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl (
    input  logic               clk_i,
    input  logic               arst_n_i,

    // fetch side
    input  logic               fetch_req_i,
    input  icache_pkg::word_t  fetch_addr_i,
    output logic               fetch_valid_o,
    output icache_pkg::word_t  fetch_data_o,
    input  logic               invalidate_i,

    // APB requester
    output logic               psel_o,
    output logic               penable_o,
    output icache_pkg::word_t  paddr_o,
    input  icache_pkg::word_t  prdata_i,
    input  logic               pready_i,

    icache_array_if.ctrl       arr_if
);
    import icache_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    word_off_t   word_cnt_q;
    word_off_t   word_cnt_d;
    word_t       addr_q;
    logic        last_word;

    // ~~~~~~~~~~~~~~~~~~~~
    // state registers
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= IDLE;
            word_cnt_q <= '0;
        end else begin
            state_q    <= state_d;
            word_cnt_q <= word_cnt_d;
        end
    end

    // the fetch address is held for the whole lookup and refill
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && fetch_req_i) begin
            addr_q <= fetch_addr_i;
        end
    end

    assign last_word = (word_cnt_q == word_off_t'(WORDS_PER_LINE - 1));

    // ~~~~~~~~~~~~~~~~~~~~
    // next state
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_d        = state_q;
        word_cnt_d     = word_cnt_q;
        arr_if.fill_we = 1'b0;
        arr_if.tag_we  = 1'b0;
        case (state_q)
            IDLE: begin
                if (fetch_req_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (arr_if.hit) begin
                    state_d = RESPOND;
                end else begin
                    state_d    = REFILL_SETUP;
                    word_cnt_d = '0;
                end
            end
            REFILL_SETUP: begin
                state_d = REFILL_ACCESS;
            end
            REFILL_ACCESS: begin
                // pready low just keeps us in the access phase
                if (pready_i) begin
                    arr_if.fill_we = 1'b1;
                    if (last_word) begin
                        // line complete, go back and look it up again
                        arr_if.tag_we = 1'b1;
                        state_d       = LOOKUP;
                    end else begin
                        word_cnt_d = word_cnt_q + 1'b1;
                        state_d    = REFILL_SETUP;
                    end
                end
            end
            RESPOND: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // outputs
    // ~~~~~~~~~~~~~~~~~~~~

    assign psel_o    = (state_q == REFILL_SETUP) || (state_q == REFILL_ACCESS);
    assign penable_o = (state_q == REFILL_ACCESS);
    assign paddr_o   = {addr_q[WORD_SIZE-1:BYTE_OFF_SIZE+WORD_OFF_SIZE], word_cnt_q,
                        {BYTE_OFF_SIZE{1'b0}}};

    assign fetch_valid_o = (state_q == RESPOND);
    assign fetch_data_o  = arr_if.rdata;

    assign arr_if.lookup_addr = addr_q;
    assign arr_if.fill_word   = word_cnt_q;
    assign arr_if.fill_data   = prdata_i;
    assign arr_if.flush       = invalidate_i && (state_q == IDLE);

endmodule : icache_ctrl

// File: verilog/icache_top.sv
`timescale 1ns/100ps

module icache_top (
    input  logic               clk_i,
    input  logic               arst_n_i,

    // fetch side
    input  logic               fetch_req_i,
    input  icache_pkg::word_t  fetch_addr_i,
    output logic               fetch_valid_o,
    output icache_pkg::word_t  fetch_data_o,
    input  logic               invalidate_i,

    // APB requester
    output logic               psel_o,
    output logic               penable_o,
    output icache_pkg::word_t  paddr_o,
    input  icache_pkg::word_t  prdata_i,
    input  logic               pready_i
);

    icache_array_if arr_if ();

    icache_ctrl u_ctrl (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_valid_o (fetch_valid_o),
        .fetch_data_o  (fetch_data_o),
        .invalidate_i  (invalidate_i),
        .psel_o        (psel_o),
        .penable_o     (penable_o),
        .paddr_o       (paddr_o),
        .prdata_i      (prdata_i),
        .pready_i      (pready_i),
        .arr_if        (arr_if)
    );

    icache_tag u_tag (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .arr_if   (arr_if)
    );

    icache_data u_data (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .arr_if   (arr_if)
    );

endmodule : icache_top

// File: verification/icache_chk.sv
`timescale 1ns/100ps

module icache_chk (
    input logic                     clk_i,
    input logic                     arst_n_i,
    input logic                     psel_o,
    input logic                     penable_o,
    input icache_pkg::word_t        paddr_o,
    input logic                     pready_i,
    input logic                     fetch_valid_o,
    input icache_pkg::ctrl_state_t  state_q
);
    import icache_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~
    // APB rules
    // ~~~~~~~~~~~~~~~~~~~~

    enable_needs_sel: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        penable_o |-> psel_o)
        else $error("penable_o high while psel_o is low");

    // the address may only move once a transfer has completed
    addr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (psel_o && !(penable_o && pready_i)) |=> $stable(paddr_o))
        else $error("paddr_o changed during an open transfer");

    // a refill only opens after a lookup has missed
    sel_after_lookup: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(psel_o) |-> ($past(state_q) == LOOKUP))
        else $error("psel_o rose without a preceding lookup");

    // ~~~~~~~~~~~~~~~~~~~~
    // fetch handshake
    // ~~~~~~~~~~~~~~~~~~~~

    valid_single_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        fetch_valid_o |=> !fetch_valid_o)
        else $error("fetch_valid_o held high for two cycles");

endmodule : icache_chk

// File: verification/icache_tb.sv
`timescale 1ns/100ps

module icache_tb;
    import icache_pkg::*;

    localparam int    NUM_TESTS = 6;
    localparam word_t DATA_KEY  = 32'h5a5a_0000;
    localparam word_t LINE_A    = 32'h0000_1230;

    logic  clk_i;
    logic  arst_n_i;
    logic  fetch_req_i;
    word_t fetch_addr_i;
    logic  fetch_valid_o;
    word_t fetch_data_o;
    logic  invalidate_i;
    logic  psel_o;
    logic  penable_o;
    word_t paddr_o;
    word_t prdata_i;
    logic  pready_i;

    int    errors;
    int    checks;
    int    wait_left;
    word_t apb_addrs[$];

    icache_top UUT (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_valid_o (fetch_valid_o),
        .fetch_data_o  (fetch_data_o),
        .invalidate_i  (invalidate_i),
        .psel_o        (psel_o),
        .penable_o     (penable_o),
        .paddr_o       (paddr_o),
        .prdata_i      (prdata_i),
        .pready_i      (pready_i)
    );

    bind icache_ctrl icache_chk u_chk (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .psel_o        (psel_o),
        .penable_o     (penable_o),
        .paddr_o       (paddr_o),
        .pready_i      (pready_i),
        .fetch_valid_o (fetch_valid_o),
        .state_q       (state_q)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // APB memory model
    // ~~~~~~~~~~~~~~~~~~~~

    // pready goes high one negedge before the completing edge, so a read is logged there
    always @(negedge clk_i) begin
        if (psel_o && !penable_o) begin
            wait_left = int'($urandom_range(3, 0));
            pready_i  = 1'b0;
        end else if (psel_o && penable_o && !pready_i) begin
            if (wait_left == 0) begin
                pready_i = 1'b1;
                prdata_i = paddr_o ^ DATA_KEY;
                apb_addrs.push_back(paddr_o);
            end else begin
                wait_left--;
            end
        end else begin
            pready_i = 1'b0;
        end
    end

    initial begin
        #(NUM_TESTS * 400 * 20);
        $display("watchdog: the run timed out before all tests finished");
        $display("TEST FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input string what, input word_t actual, input word_t expected);
        checks++;
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        $display("test %s: %s", name, (errors == start_errors) ? "pass" : "fail");
    endtask

    // called on a negedge with the DUT idle, returns on a negedge with the DUT idle again
    task automatic fetch(input word_t addr, output word_t data, output int cycles);
        fetch_req_i  = 1'b1;
        fetch_addr_i = addr;
        cycles       = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!fetch_valid_o);
        data        = fetch_data_o;
        fetch_req_i = 1'b0;
        @(negedge clk_i);
    endtask

    task automatic check_line_reads(input word_t addr);
        word_t base;
        base = addr & ~32'h0000_000f;
        check_value("APB read count", word_t'(apb_addrs.size()), 32'd4);
        for (int i = 0; i < apb_addrs.size() && i < 4; i++) begin
            check_value("APB read address", apb_addrs[i], base + word_t'(4 * i));
        end
    endtask

    task automatic pulse_invalidate();
        invalidate_i = 1'b1;
        @(negedge clk_i);
        invalidate_i = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~

    task automatic test_reset();
        int start_err;
        start_err = errors;
        check_value("psel_o after reset", word_t'(psel_o), 32'd0);
        check_value("penable_o after reset", word_t'(penable_o), 32'd0);
        check_value("fetch_valid_o after reset", word_t'(fetch_valid_o), 32'd0);
        report_test("reset state", start_err);
    endtask

    task automatic test_cold_miss();
        word_t data;
        int    cycles;
        int    start_err;
        start_err = errors;
        apb_addrs.delete();
        fetch(LINE_A + 32'h8, data, cycles);
        check_line_reads(LINE_A);
        check_value("cold miss data", data, (LINE_A + 32'h8) ^ DATA_KEY);
        report_test("cold miss", start_err);
    endtask

    task automatic test_hit();
        word_t addr;
        word_t data;
        int    cycles;
        int    start_err;
        start_err = errors;
        for (int i = 0; i < 4; i++) begin
            addr = LINE_A + word_t'(4 * i);
            apb_addrs.delete();
            fetch(addr, data, cycles);
            check_value("APB reads on hit", word_t'(apb_addrs.size()), 32'd0);
            check_value("hit data", data, addr ^ DATA_KEY);
            check_value("hit latency", word_t'(cycles), 32'd2);
        end
        report_test("hit", start_err);
    endtask

    task automatic test_conflict();
        word_t other;
        word_t data;
        int    cycles;
        int    start_err;
        start_err = errors;
        // same index, one tag bit flipped
        other = LINE_A ^ 32'h0000_0400;
        apb_addrs.delete();
        fetch(other + 32'h4, data, cycles);
        check_line_reads(other);
        check_value("conflict data", data, (other + 32'h4) ^ DATA_KEY);
        apb_addrs.delete();
        fetch(LINE_A, data, cycles);
        check_line_reads(LINE_A);
        check_value("evicted line data", data, LINE_A ^ DATA_KEY);
        report_test("conflict eviction", start_err);
    endtask

    task automatic test_invalidate();
        word_t data;
        int    cycles;
        int    start_err;
        start_err = errors;
        apb_addrs.delete();
        fetch(LINE_A, data, cycles);
        check_value("APB reads before invalidate", word_t'(apb_addrs.size()), 32'd0);
        pulse_invalidate();
        apb_addrs.delete();
        fetch(LINE_A + 32'hc, data, cycles);
        check_line_reads(LINE_A);
        check_value("data after invalidate", data, (LINE_A + 32'hc) ^ DATA_KEY);
        report_test("invalidate", start_err);
    endtask

    task automatic test_random();
        logic   mvalid [NUM_LINES];
        tag_t   mtag [NUM_LINES];
        word_t  addr;
        word_t  data;
        index_t idx;
        tag_t   tag;
        int     cycles;
        int     misses;
        int     start_err;
        start_err = errors;
        misses    = 0;
        pulse_invalidate();
        for (int i = 0; i < NUM_LINES; i++) begin
            mvalid[i] = 1'b0;
            mtag[i]   = '0;
        end
        apb_addrs.delete();
        for (int n = 0; n < 40; n++) begin
            addr = $urandom & 32'h0000_0ffc;
            idx  = addr[BYTE_OFF_SIZE+WORD_OFF_SIZE +: INDEX_SIZE];
            tag  = addr[WORD_SIZE-1 -: TAG_SIZE];
            if (!mvalid[idx] || mtag[idx] != tag) begin
                misses++;
                mvalid[idx] = 1'b1;
                mtag[idx]   = tag;
            end
            fetch(addr, data, cycles);
            check_value("random fetch data", data, addr ^ DATA_KEY);
        end
        check_value("APB reads vs predicted misses", word_t'(apb_addrs.size()),
                    word_t'(4 * misses));
        report_test("wait states", start_err);
    endtask

    initial begin
        void'($urandom(32'h3e8d9047));
        arst_n_i     = 1'b0;
        fetch_req_i  = 1'b0;
        fetch_addr_i = '0;
        invalidate_i = 1'b0;
        prdata_i     = '0;
        pready_i     = 1'b0;
        errors       = 0;
        checks       = 0;
        wait_left    = 0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        @(negedge clk_i);
        test_reset();
        test_cold_miss();
        test_hit();
        test_conflict();
        test_invalidate();
        test_random();
        $display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : icache_tb

// File: sources.f
common/icache_pkg.sv
common/icache_array_if.sv
icache/icache_tag.sv
icache/icache_data.sv
icache/icache_ctrl.sv
verilog/icache_top.sv
verification/icache_chk.sv
verification/icache_tb.sv

// File: Makefile
# Verilator flow for the instruction cache testbench

TOP := icache_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sources.f -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log; then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "TEST OK" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
